// File: src/ucode_pkg.sv
package ucode_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int INSTR_W    = 128;
    localparam int FIELD_W    = 16;
    localparam int BYTE_W     = 8;
    localparam int NUM_ENG    = 4;
    localparam int ENG_ID_W   = 2;
    localparam int DONE_CNT_W = 16;

    // --------------------
    // Field positions in the instruction word
    // --------------------
    localparam int OPCODE_LSB = 0;
    localparam int FLAGS_LSB  = 8;
    localparam int DST_LSB    = 16;
    localparam int SRC0_LSB   = 32;
    localparam int SRC1_LSB   = 48;
    localparam int M_LSB      = 64;
    localparam int N_LSB      = 80;
    localparam int K_LSB      = 96;
    localparam int IMM_LSB    = 112;

    // Opcodes not listed here decode as NOP
    typedef enum logic [BYTE_W-1:0] {
        OP_NOP       = 8'h00,
        OP_DMA_LOAD  = 8'h01,
        OP_DMA_STORE = 8'h02,
        OP_GEMM      = 8'h03,
        OP_VEC       = 8'h04,
        OP_BARRIER   = 8'h0E,
        OP_END       = 8'h0F
    } opcode_e;

    // Engine lane numbers, also the index into the port vectors
    typedef enum logic [ENG_ID_W-1:0] {
        ENG_DMA_RD = 2'd0,
        ENG_DMA_WR = 2'd1,
        ENG_GEMM   = 2'd2,
        ENG_VEC    = 2'd3
    } engine_e;

    // Member order mirrors the instruction layout, opcode in the low byte
    typedef struct packed {
        logic [FIELD_W-1:0] imm;
        logic [FIELD_W-1:0] k;
        logic [FIELD_W-1:0] n;
        logic [FIELD_W-1:0] m;
        logic [FIELD_W-1:0] src1;
        logic [FIELD_W-1:0] src0;
        logic [FIELD_W-1:0] dst;
        logic [BYTE_W-1:0]  flags;
        logic [BYTE_W-1:0]  opcode;
    } engine_cmd_t;

    typedef enum logic [1:0] {
        D_IDLE    = 2'd0,
        D_ACK     = 2'd1,
        D_BARRIER = 2'd2
    } decode_state_e;

endpackage

// File: src/dispatch_if.sv
`timescale 1ns/1ps

interface dispatch_if (
    input logic clk
);

    // One-hot issue pulse plus the command that goes with it
    logic [ucode_pkg::NUM_ENG-1:0] issue;
    ucode_pkg::engine_cmd_t        cmd;

    // Per-lane status from the engine ports
    logic [ucode_pkg::NUM_ENG-1:0] busy;
    logic [ucode_pkg::NUM_ENG-1:0] done;

    logic                          all_idle;
    logic                          end_seen;

    modport decoder (
        input  clk,
        output issue,
        output cmd,
        output end_seen,
        input  busy,
        input  all_idle
    );

    // Each port drives only its own bit of busy and done
    modport port (
        input  clk,
        input  issue,
        input  cmd,
        output busy,
        output done
    );

    modport tracker (
        input  clk,
        input  busy,
        input  done,
        input  end_seen,
        output all_idle
    );

endinterface

// File: src/ucode_decoder.sv
`timescale 1ns/1ps

module ucode_decoder (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          instr_req,
    input  logic [ucode_pkg::INSTR_W-1:0] instr_data,
    output logic                          instr_ack,
    dispatch_if.decoder                   disp
);

    ucode_pkg::engine_cmd_t        word_cmd;
    ucode_pkg::opcode_e            word_op;
    ucode_pkg::engine_e            word_eng;
    logic                          word_is_eng;
    logic                          word_is_barrier;
    logic                          word_is_end;
    logic [ucode_pkg::NUM_ENG-1:0] word_onehot;
    logic                          accept;

    ucode_pkg::decode_state_e      state_q;
    logic                          barrier_q;

    // --------------------
    // Field extraction
    // --------------------
    always_comb begin
        word_cmd.opcode = instr_data[ucode_pkg::OPCODE_LSB +: ucode_pkg::BYTE_W];
        word_cmd.flags  = instr_data[ucode_pkg::FLAGS_LSB  +: ucode_pkg::BYTE_W];
        word_cmd.dst    = instr_data[ucode_pkg::DST_LSB    +: ucode_pkg::FIELD_W];
        word_cmd.src0   = instr_data[ucode_pkg::SRC0_LSB   +: ucode_pkg::FIELD_W];
        word_cmd.src1   = instr_data[ucode_pkg::SRC1_LSB   +: ucode_pkg::FIELD_W];
        word_cmd.m      = instr_data[ucode_pkg::M_LSB      +: ucode_pkg::FIELD_W];
        word_cmd.n      = instr_data[ucode_pkg::N_LSB      +: ucode_pkg::FIELD_W];
        word_cmd.k      = instr_data[ucode_pkg::K_LSB      +: ucode_pkg::FIELD_W];
        word_cmd.imm    = instr_data[ucode_pkg::IMM_LSB    +: ucode_pkg::FIELD_W];
    end

    assign word_op = ucode_pkg::opcode_e'(word_cmd.opcode);

    // --------------------
    // Opcode decode
    // --------------------
    always_comb begin
        word_eng        = ucode_pkg::ENG_DMA_RD;
        word_is_eng     = 1'b0;
        word_is_barrier = 1'b0;
        word_is_end     = 1'b0;
        case (word_op)
            ucode_pkg::OP_DMA_LOAD: begin
                word_eng    = ucode_pkg::ENG_DMA_RD;
                word_is_eng = 1'b1;
            end
            ucode_pkg::OP_DMA_STORE: begin
                word_eng    = ucode_pkg::ENG_DMA_WR;
                word_is_eng = 1'b1;
            end
            ucode_pkg::OP_GEMM: begin
                word_eng    = ucode_pkg::ENG_GEMM;
                word_is_eng = 1'b1;
            end
            ucode_pkg::OP_VEC: begin
                word_eng    = ucode_pkg::ENG_VEC;
                word_is_eng = 1'b1;
            end
            ucode_pkg::OP_BARRIER: word_is_barrier = 1'b1;
            ucode_pkg::OP_END:     word_is_end = 1'b1;
            // NOP and unknown opcodes are simply consumed
            default: ;
        endcase
    end

    always_comb begin
        word_onehot           = '0;
        word_onehot[word_eng] = 1'b1;
    end

    // Take the word unless its engine is still running
    assign accept = (state_q == ucode_pkg::D_IDLE) && instr_req &&
                    (!word_is_eng || !disp.busy[word_eng]);

    // --------------------
    // Fetch handshake FSM
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= ucode_pkg::D_IDLE;
            instr_ack     <= 1'b0;
            barrier_q     <= 1'b0;
            disp.issue    <= '0;
            disp.end_seen <= 1'b0;
        end else begin
            disp.issue    <= '0;
            disp.end_seen <= 1'b0;
            case (state_q)
                ucode_pkg::D_IDLE: begin
                    if (accept) begin
                        instr_ack     <= 1'b1;
                        barrier_q     <= word_is_barrier;
                        disp.end_seen <= word_is_end;
                        if (word_is_eng) begin
                            disp.issue <= word_onehot;
                        end
                        state_q <= ucode_pkg::D_ACK;
                    end
                end
                ucode_pkg::D_ACK: begin
                    // Return to zero once fetch has dropped its request
                    if (!instr_req) begin
                        instr_ack <= 1'b0;
                        state_q   <= barrier_q ? ucode_pkg::D_BARRIER : ucode_pkg::D_IDLE;
                    end
                end
                ucode_pkg::D_BARRIER: begin
                    if (disp.all_idle) begin
                        state_q <= ucode_pkg::D_IDLE;
                    end
                end
                default: state_q <= ucode_pkg::D_IDLE;
            endcase
        end
    end

    // Command payload, valid alongside the issue pulse
    always_ff @(posedge clk) begin
        if (accept && word_is_eng) begin
            disp.cmd <= word_cmd;
        end
    end

endmodule

// File: src/engine_port.sv
`timescale 1ns/1ps

module engine_port #(
    parameter int ENG_IDX = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    dispatch_if.port               disp,
    output logic                   eng_req,
    input  logic                   eng_ack,
    output ucode_pkg::engine_cmd_t eng_cmd
);

    // Outgoing four-phase handshake
    typedef enum logic [1:0] {
        P_IDLE    = 2'd0,
        P_REQ     = 2'd1,
        P_RELEASE = 2'd2
    } port_state_e;

    port_state_e state_q;
    logic        done_q;
    logic        take;

    assign take = (state_q == P_IDLE) && disp.issue[ENG_IDX];

    // --------------------
    // Handshake state
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= P_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                P_IDLE: begin
                    if (take) begin
                        state_q <= P_REQ;
                    end
                end
                // Engine acks on completion, then we drop req
                P_REQ: begin
                    if (eng_ack) begin
                        state_q <= P_RELEASE;
                    end
                end
                P_RELEASE: begin
                    if (!eng_ack) begin
                        state_q <= P_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            eng_cmd <= disp.cmd;
        end
    end

    assign eng_req = (state_q == P_REQ);

    // Busy covers both req high and the wait for ack to fall
    assign disp.busy[ENG_IDX] = (state_q != P_IDLE);
    assign disp.done[ENG_IDX] = done_q;

endmodule

// File: src/completion_tracker.sv
`timescale 1ns/1ps

module completion_tracker (
    input  logic                             clk,
    input  logic                             rst_n,
    dispatch_if.tracker                      disp,
    output logic [ucode_pkg::DONE_CNT_W-1:0] done_count,
    output logic                             program_done
);

    logic [ucode_pkg::DONE_CNT_W-1:0] done_num;
    logic                             end_q;

    // --------------------
    // Idle detection
    // --------------------
    // Combinational so a barrier can release the same cycle the last lane frees
    assign disp.all_idle = ~|disp.busy;

    // Several lanes may finish in one cycle
    always_comb begin
        done_num = '0;
        for (int i = 0; i < ucode_pkg::NUM_ENG; i++) begin
            done_num = done_num + disp.done[i];
        end
    end

    // --------------------
    // Counting and end of program
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_count   <= '0;
            end_q        <= 1'b0;
            program_done <= 1'b0;
        end else begin
            done_count <= done_count + done_num;
            if (disp.end_seen) begin
                end_q <= 1'b1;
            end
            // Sticky until reset
            if (end_q && disp.all_idle) begin
                program_done <= 1'b1;
            end
        end
    end

endmodule

// File: src/ucode_dispatch.sv
`timescale 1ns/1ps

module ucode_dispatch (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             instr_req,
    input  logic [ucode_pkg::INSTR_W-1:0]    instr_data,
    output logic                             instr_ack,
    output logic [ucode_pkg::NUM_ENG-1:0]    eng_req,
    input  logic [ucode_pkg::NUM_ENG-1:0]    eng_ack,
    output ucode_pkg::engine_cmd_t           eng_cmd [ucode_pkg::NUM_ENG],
    output logic [ucode_pkg::DONE_CNT_W-1:0] done_count,
    output logic                             program_done
);

    dispatch_if disp_if (
        .clk (clk)
    );

    ucode_decoder ucode_decoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_req  (instr_req),
        .instr_data (instr_data),
        .instr_ack  (instr_ack),
        .disp       (disp_if.decoder)
    );

    // One port per engine lane, indexed by engine_e
    for (genvar g = 0; g < ucode_pkg::NUM_ENG; g++) begin : g_port
        engine_port #(
            .ENG_IDX (g)
        ) engine_port_i (
            .clk     (clk),
            .rst_n   (rst_n),
            .disp    (disp_if.port),
            .eng_req (eng_req[g]),
            .eng_ack (eng_ack[g]),
            .eng_cmd (eng_cmd[g])
        );
    end

    completion_tracker completion_tracker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .disp         (disp_if.tracker),
        .done_count   (done_count),
        .program_done (program_done)
    );

endmodule

// File: bench/ucode_dispatch_assertions.sv
`timescale 1ns/1ps

module ucode_dispatch_assertions (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          instr_req,
    input logic                          instr_ack,
    input logic [ucode_pkg::INSTR_W-1:0] instr_data,
    input logic [ucode_pkg::NUM_ENG-1:0] eng_req,
    input logic [ucode_pkg::NUM_ENG-1:0] eng_ack,
    input ucode_pkg::engine_cmd_t        eng_cmd [ucode_pkg::NUM_ENG],
    input logic                          program_done
);

    int   fail_count = 0;
    logic ack_q;
    logic after_barrier;
    logic end_acked;

    // Opcode that belongs on each engine lane
    function automatic logic [7:0] lane_op(input int lane);
        case (lane)
            0:       return ucode_pkg::OP_DMA_LOAD;
            1:       return ucode_pkg::OP_DMA_STORE;
            2:       return ucode_pkg::OP_GEMM;
            default: return ucode_pkg::OP_VEC;
        endcase
    endfunction

    // Class of the word whose acknowledge rose last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q         <= 1'b0;
            after_barrier <= 1'b0;
            end_acked     <= 1'b0;
        end else begin
            ack_q <= instr_ack;
            if (instr_ack && !ack_q) begin
                after_barrier <= (instr_data[7:0] == ucode_pkg::OP_BARRIER);
                if (instr_data[7:0] == ucode_pkg::OP_END) begin
                    end_acked <= 1'b1;
                end
            end
        end
    end

    // --------------------
    // Fetch handshake
    // --------------------
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(instr_ack) |-> $past(instr_req))
    else begin
        fail_count++;
        $error("instr_ack rose without instr_req high");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(instr_ack) |-> !$past(instr_req))
    else begin
        fail_count++;
        $error("instr_ack fell while instr_req was still high");
    end

    // --------------------
    // Routing and back-pressure per lane
    // --------------------
    for (genvar g = 0; g < ucode_pkg::NUM_ENG; g++) begin : g_lane
        assert property (@(posedge clk) disable iff (!rst_n)
            $rose(instr_ack) && (instr_data[7:0] == lane_op(g)) |=> $rose(eng_req[g]))
        else begin
            fail_count++;
            $error("eng_req[%0d] did not rise one cycle after instr_ack", g);
        end

        assert property (@(posedge clk) disable iff (!rst_n)
            $rose(eng_req[g]) |-> eng_cmd[g].opcode == lane_op(g))
        else begin
            fail_count++;
            $error("Opcode %h issued on the wrong lane %0d", eng_cmd[g].opcode, g);
        end

        // Word for a running engine must wait for its lane to return to zero
        assert property (@(posedge clk) disable iff (!rst_n)
            $rose(instr_ack) && (instr_data[7:0] == lane_op(g)) |->
                $past(!eng_req[g] && !eng_ack[g]))
        else begin
            fail_count++;
            $error("Word for lane %0d acknowledged while the lane was busy", g);
        end

        assert property (@(posedge clk) disable iff (!rst_n)
            $rose(eng_req[g]) |-> $past(!eng_ack[g]))
        else begin
            fail_count++;
            $error("eng_req[%0d] rose again before the handshake completed", g);
        end
    end

    // --------------------
    // Barrier and end of program
    // --------------------
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(instr_ack) && after_barrier |-> $past(eng_req == '0 && eng_ack == '0))
    else begin
        fail_count++;
        $error("Word after a barrier acknowledged while engines were active");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(program_done) |-> $past(end_acked && eng_req == '0 && eng_ack == '0))
    else begin
        fail_count++;
        $error("program_done rose before END or with engines active");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        program_done |=> program_done)
    else begin
        fail_count++;
        $error("program_done dropped before reset");
    end

endmodule

bind ucode_dispatch ucode_dispatch_assertions asrt_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_req    (instr_req),
    .instr_ack    (instr_ack),
    .instr_data   (instr_data),
    .eng_req      (eng_req),
    .eng_ack      (eng_ack),
    .eng_cmd      (eng_cmd),
    .program_done (program_done)
);

// File: bench/tb_ucode_dispatch.sv
`timescale 1ns/1ps

module tb_ucode_dispatch;

    localparam int TIMEOUT = 200;

    logic                             clk = 1'b0;
    logic                             rst_n;
    logic                             instr_req;
    logic [ucode_pkg::INSTR_W-1:0]    instr_data;
    logic                             instr_ack;
    logic [ucode_pkg::NUM_ENG-1:0]    eng_req;
    wire  [ucode_pkg::NUM_ENG-1:0]    eng_ack;
    ucode_pkg::engine_cmd_t           eng_cmd [ucode_pkg::NUM_ENG];
    logic [ucode_pkg::DONE_CNT_W-1:0] done_count;
    logic                             program_done;

    integer                           seed = 32'h956f_1440;
    int                               error_count = 0;
    int                               cmds_sent = 0;
    logic [ucode_pkg::INSTR_W-1:0]    exp_word [ucode_pkg::NUM_ENG];

    // Two GEMMs back to back, NOP, unknown opcode, barrier, then END
    logic [7:0] program_ops [12] = '{8'h01, 8'h02, 8'h03, 8'h03, 8'h04, 8'h00,
                                     8'h55, 8'h0E, 8'h04, 8'h03, 8'h01, 8'h0F};

    always #50 clk = ~clk;

    ucode_dispatch ucode_dispatch_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_req    (instr_req),
        .instr_data   (instr_data),
        .instr_ack    (instr_ack),
        .eng_req      (eng_req),
        .eng_ack      (eng_ack),
        .eng_cmd      (eng_cmd),
        .done_count   (done_count),
        .program_done (program_done)
    );

    // Engine lane for each engine opcode, -1 for everything else
    function automatic int lane_of(input logic [7:0] op);
        case (op)
            8'h01:   return 0;
            8'h02:   return 1;
            8'h03:   return 2;
            8'h04:   return 3;
            default: return -1;
        endcase
    endfunction

    task automatic check_field(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // --------------------
    // Field scoreboard
    // --------------------
    task automatic compare_cmd(input int lane);
        logic [ucode_pkg::INSTR_W-1:0] w;
        w = exp_word[lane];
        check_field($sformatf("eng_cmd[%0d].opcode", lane), eng_cmd[lane].opcode, w[7:0]);
        check_field($sformatf("eng_cmd[%0d].flags", lane), eng_cmd[lane].flags, w[15:8]);
        check_field($sformatf("eng_cmd[%0d].dst", lane), eng_cmd[lane].dst, w[31:16]);
        check_field($sformatf("eng_cmd[%0d].src0", lane), eng_cmd[lane].src0, w[47:32]);
        check_field($sformatf("eng_cmd[%0d].src1", lane), eng_cmd[lane].src1, w[63:48]);
        check_field($sformatf("eng_cmd[%0d].m", lane), eng_cmd[lane].m, w[79:64]);
        check_field($sformatf("eng_cmd[%0d].n", lane), eng_cmd[lane].n, w[95:80]);
        check_field($sformatf("eng_cmd[%0d].k", lane), eng_cmd[lane].k, w[111:96]);
        check_field($sformatf("eng_cmd[%0d].imm", lane), eng_cmd[lane].imm, w[127:112]);
    endtask

    // Four-phase fetch transfer of one word
    task automatic send_word(input logic [ucode_pkg::INSTR_W-1:0] word);
        int wait_cnt;
        int lane;
        wait_cnt = 0;
        lane     = lane_of(word[7:0]);
        @(negedge clk);
        instr_data = word;
        instr_req  = 1'b1;
        while (!instr_ack && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!instr_ack) begin
            $display("Timeout: instr_ack never rose for opcode %h", word[7:0]);
            error_count++;
        end else if (lane >= 0) begin
            exp_word[lane] = word;
            cmds_sent++;
        end
        instr_req = 1'b0;
        wait_cnt  = 0;
        while (instr_ack && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (instr_ack) begin
            $display("Timeout: instr_ack stayed high after instr_req fell");
            error_count++;
        end
    endtask

    // --------------------
    // Engine models
    // --------------------
    for (genvar g = 0; g < ucode_pkg::NUM_ENG; g++) begin : g_engine
        logic ack = 1'b0;
        int   left = 0;

        assign eng_ack[g] = ack;

        always @(negedge clk) begin
            if (!eng_req[g]) begin
                ack  = 1'b0;
                left = 0;
            end else if (!ack) begin
                if (left == 0) begin
                    // Fresh command, check it and pick a finish time of 1 to 8 cycles
                    compare_cmd(g);
                    left = 1 + {$random(seed)} % 8;
                end
                left = left - 1;
                if (left == 0) begin
                    ack = 1'b1;
                end
            end
        end
    end

    initial begin
        logic [ucode_pkg::INSTR_W-1:0] word;
        int                            wait_cnt;
        rst_n      = 1'b0;
        instr_req  = 1'b0;
        instr_data = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        foreach (program_ops[i]) begin
            word      = {$random(seed), $random(seed), $random(seed), $random(seed)};
            word[7:0] = program_ops[i];
            send_word(word);
        end

        wait_cnt = 0;
        while (!program_done && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!program_done) begin
            $display("Timeout: program_done never rose after END");
            error_count++;
        end
        if (done_count !== 16'(cmds_sent)) begin
            $display("Error: done_count got %h expected %h", done_count, 16'(cmds_sent));
            error_count++;
        end

        $display("Check errors: %0d, assertion failures: %0d", error_count,
                 ucode_dispatch_i.asrt_i.fail_count);
        if (error_count == 0 && ucode_dispatch_i.asrt_i.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
src/ucode_pkg.sv
src/dispatch_if.sv
src/ucode_decoder.sv
src/engine_port.sv
src/completion_tracker.sv
src/ucode_dispatch.sv
bench/ucode_dispatch_assertions.sv
bench/tb_ucode_dispatch.sv

// File: Bender.yml
package:
  name: ucode_dispatch

sources:
  - src/ucode_pkg.sv
  - src/dispatch_if.sv
  - src/ucode_decoder.sv
  - src/engine_port.sv
  - src/completion_tracker.sv
  - src/ucode_dispatch.sv
  - target: test
    files:
      - bench/ucode_dispatch_assertions.sv
      - bench/tb_ucode_dispatch.sv
